//--- source/sniffer_cfg.svh
//----------------------------------------------------------
// Widths, FIFO depth and source ids of the bus sniffer
// Frame fields must add up to SNIFFER_FRAME_W
//----------------------------------------------------------
`ifndef SNIFFER_CFG_SVH
`define SNIFFER_CFG_SVH

// Bus field widths
`define SNIFFER_ADDR_W 32
`define SNIFFER_DATA_W 32
`define SNIFFER_BE_W 4
`define SNIFFER_TS_W 32

`define SNIFFER_FRAME_W 128
`define SNIFFER_FIFO_DEPTH 16  // Power of two

// Source ids carried in the frame MSBs
`define SNIFFER_SRC_INSTR_REQ 8'h01
`define SNIFFER_SRC_INSTR_RESP 8'h02
`define SNIFFER_SRC_DATA_REQ 8'h03
`define SNIFFER_SRC_DATA_RESP 8'h04

`endif

//--- source/sniffer_pkg.sv
//----------------------------------------------------------
// Types shared by the sniffer RTL and its testbench
//----------------------------------------------------------
`include "sniffer_cfg.svh"

package sniffer_pkg;

  typedef logic [`SNIFFER_ADDR_W-1:0] addr_t;
  typedef logic [`SNIFFER_DATA_W-1:0] data_t;
  typedef logic [`SNIFFER_BE_W-1:0] be_t;
  typedef logic [`SNIFFER_TS_W-1:0] ts_t;
  typedef logic [7:0] src_id_t;

  // Padding that fills the frame up to its full width
  localparam int ReservedW = `SNIFFER_FRAME_W - 8 - `SNIFFER_TS_W - `SNIFFER_ADDR_W
                             - `SNIFFER_DATA_W - `SNIFFER_BE_W - 3;

  //----------------------------------------------------------
  // Frame layout, MSB first
  //----------------------------------------------------------
  typedef struct packed {
    src_id_t              source_id;    // 127..120
    ts_t                  timestamp;    // 119..88
    addr_t                address;      // 87..56
    data_t                data;         // 55..24
    be_t                  byte_enable;  // 23..20
    logic                 we;           // 19
    logic                 valid;        // 18
    logic                 gnt;          // 17
    logic [ReservedW-1:0] reserved;     // Always zero
  } frame_t;

  // Serializer FSM
  typedef enum logic {
    IDLE,
    SHIFT
  } ser_state_e;

endpackage

//--- source/bus_mon_if.sv
//----------------------------------------------------------
// One monitored request/response bus port
// The sniffer only observes, every signal is an input to it
//----------------------------------------------------------
interface bus_mon_if;
  import sniffer_pkg::*;

  // Request side
  logic  req;
  addr_t addr;
  data_t wdata;
  be_t   be;
  logic  we;

  // Response side
  logic  rvalid;
  data_t rdata;
  logic  gnt;

  modport mon (
    input req, addr, wdata, be, we,
    input rvalid, rdata, gnt
  );

endinterface

//--- source/event_capture.sv
//----------------------------------------------------------
// One event per clock by fixed priority, lower ones are lost
// Timestamp counts edges since reset release, starting at 0
//----------------------------------------------------------
`include "sniffer_cfg.svh"

module event_capture (
  input  logic                clk_i,
  input  logic                rst_ni,
  bus_mon_if.mon              instr_bus,
  bus_mon_if.mon              data_bus,
  output logic                push_o,
  output sniffer_pkg::frame_t frame_o
);
  import sniffer_pkg::*;

  ts_t ts_q;

  //----------------------------------------------------------
  // Free-running timestamp
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + ts_t'(1);  // Wraps silently
    end
  end

  // Fills every frame field, valid is always set for a captured event
  function automatic frame_t build_frame(
    input src_id_t id,
    input ts_t     ts,
    input addr_t   addr,
    input data_t   data,
    input be_t     be,
    input logic    we,
    input logic    gnt
  );
    frame_t f;
    f.source_id   = id;
    f.timestamp   = ts;
    f.address     = addr;
    f.data        = data;
    f.byte_enable = be;
    f.we          = we;
    f.valid       = 1'b1;
    f.gnt         = gnt;
    f.reserved    = '0;
    return f;
  endfunction

  //----------------------------------------------------------
  // Priority select
  //----------------------------------------------------------
  // instr req > instr resp > data req > data resp
  always_comb begin
    push_o  = 1'b1;
    frame_o = '0;
    if (instr_bus.req) begin
      frame_o = build_frame(`SNIFFER_SRC_INSTR_REQ, ts_q, instr_bus.addr,
                            instr_bus.wdata, instr_bus.be, instr_bus.we, 1'b1);
    end else if (instr_bus.rvalid) begin
      // Responses carry no address, be or we
      frame_o = build_frame(`SNIFFER_SRC_INSTR_RESP, ts_q, '0,
                            instr_bus.rdata, '0, 1'b0, instr_bus.gnt);
    end else if (data_bus.req) begin
      frame_o = build_frame(`SNIFFER_SRC_DATA_REQ, ts_q, data_bus.addr,
                            data_bus.wdata, data_bus.be, data_bus.we, 1'b1);
    end else if (data_bus.rvalid) begin
      frame_o = build_frame(`SNIFFER_SRC_DATA_RESP, ts_q, '0,
                            data_bus.rdata, '0, 1'b0, data_bus.gnt);
    end else begin
      push_o = 1'b0;  // Quiet cycle
    end
  end

endmodule

//--- source/frame_fifo.sv
//----------------------------------------------------------
// Depth must be a power of two, at least 2
// A push while full is dropped even if a pop happens then
//----------------------------------------------------------
`include "sniffer_cfg.svh"

module frame_fifo #(
  parameter int Depth = `SNIFFER_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  sniffer_pkg::frame_t frame_i,
  input  logic                pop_i,
  output sniffer_pkg::frame_t frame_o,
  output logic                empty_o
);
  import sniffer_pkg::*;

  localparam int PtrW = $clog2(Depth);

  frame_t          mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;   // One extra bit to tell full from empty
  logic            full;
  logic            push_ok;

  assign full    = (count_q == (PtrW + 1)'(Depth));
  assign push_ok = push_i && !full;
  assign empty_o = (count_q == '0);
  assign frame_o = mem_q[rd_ptr_q];  // Head frame

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= frame_i;
    end
  end

  //----------------------------------------------------------
  // Pointers and fill count
  //----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at Depth
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

endmodule

//--- source/frame_serializer.sv
//----------------------------------------------------------
// Frames go out LSB first, one bit per clock, outputs registered
// At least one idle clock with valid low between two frames
//----------------------------------------------------------
`include "sniffer_cfg.svh"

module frame_serializer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                empty_i,
  input  sniffer_pkg::frame_t frame_i,
  output logic                pop_o,
  output logic                sniffer_tdo_o,
  output logic                sniffer_valid_o
);
  import sniffer_pkg::*;

  localparam int CntW = $clog2(`SNIFFER_FRAME_W);

  ser_state_e                  state_q;
  ser_state_e                  state_d;
  logic [`SNIFFER_FRAME_W-1:0] shift_q;
  logic [CntW-1:0]             bit_cnt_q;
  logic                        last_bit;
  logic                        tdo_q;
  logic                        valid_q;

  assign pop_o    = (state_q == IDLE) && !empty_i;  // Take head when idle
  assign last_bit = (bit_cnt_q == CntW'(`SNIFFER_FRAME_W - 1));

  //----------------------------------------------------------
  // FSM
  //----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (!empty_i) begin
          state_d = SHIFT;
        end
      end
      SHIFT: begin
        if (last_bit) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      tdo_q     <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == SHIFT) begin
        tdo_q     <= shift_q[0];
        valid_q   <= 1'b1;
        bit_cnt_q <= bit_cnt_q + 1'b1;  // Back to 0 after the last bit
      end else begin
        tdo_q     <= 1'b0;  // Line held low between frames
        valid_q   <= 1'b0;
        bit_cnt_q <= '0;
      end
    end
  end

  // Shift register, loaded on pop
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shift_q <= frame_i;
    end else if (state_q == SHIFT) begin
      shift_q <= {1'b0, shift_q[`SNIFFER_FRAME_W-1:1]};
    end
  end

  assign sniffer_tdo_o   = tdo_q;
  assign sniffer_valid_o = valid_q;

endmodule

//--- source/bus_sniffer.sv
//----------------------------------------------------------
// Sniffer for the core instr and data ports
// Events past a full FIFO or below the winner are lost
//----------------------------------------------------------
`include "sniffer_cfg.svh"

module bus_sniffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Core instruction port
  input  logic                instr_req_i,
  input  sniffer_pkg::addr_t  instr_addr_i,
  input  sniffer_pkg::data_t  instr_wdata_i,
  input  sniffer_pkg::be_t    instr_be_i,
  input  logic                instr_we_i,
  input  logic                instr_rvalid_i,
  input  sniffer_pkg::data_t  instr_rdata_i,
  input  logic                instr_gnt_i,
  // Core data port
  input  logic                data_req_i,
  input  sniffer_pkg::addr_t  data_addr_i,
  input  sniffer_pkg::data_t  data_wdata_i,
  input  sniffer_pkg::be_t    data_be_i,
  input  logic                data_we_i,
  input  logic                data_rvalid_i,
  input  sniffer_pkg::data_t  data_rdata_i,
  input  logic                data_gnt_i,
  // Serial trace
  output logic                sniffer_tdo_o,
  output logic                sniffer_valid_o
);
  import sniffer_pkg::*;

  logic   push;
  frame_t cap_frame;
  logic   pop;
  logic   empty;
  frame_t head_frame;

  //----------------------------------------------------------
  // Bus ports into interfaces
  //----------------------------------------------------------
  bus_mon_if instr_bus ();
  bus_mon_if data_bus ();

  assign instr_bus.req    = instr_req_i;
  assign instr_bus.addr   = instr_addr_i;
  assign instr_bus.wdata  = instr_wdata_i;
  assign instr_bus.be     = instr_be_i;
  assign instr_bus.we     = instr_we_i;
  assign instr_bus.rvalid = instr_rvalid_i;
  assign instr_bus.rdata  = instr_rdata_i;
  assign instr_bus.gnt    = instr_gnt_i;

  assign data_bus.req    = data_req_i;
  assign data_bus.addr   = data_addr_i;
  assign data_bus.wdata  = data_wdata_i;
  assign data_bus.be     = data_be_i;
  assign data_bus.we     = data_we_i;
  assign data_bus.rvalid = data_rvalid_i;
  assign data_bus.rdata  = data_rdata_i;
  assign data_bus.gnt    = data_gnt_i;

  //----------------------------------------------------------
  // Capture, buffer, serialize
  //----------------------------------------------------------
  event_capture u_capture (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .instr_bus (instr_bus),
    .data_bus  (data_bus),
    .push_o    (push),
    .frame_o   (cap_frame)
  );

  frame_fifo #(
    .Depth (`SNIFFER_FIFO_DEPTH)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .frame_i (cap_frame),
    .pop_i   (pop),
    .frame_o (head_frame),
    .empty_o (empty)
  );

  frame_serializer u_serializer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .empty_i         (empty),
    .frame_i         (head_frame),
    .pop_o           (pop),
    .sniffer_tdo_o   (sniffer_tdo_o),
    .sniffer_valid_o (sniffer_valid_o)
  );

endmodule

//--- tb/tb_bus_sniffer.sv
//----------------------------------------------------------
// Expected frames come from a model of the 16-deep FIFO
// and of the serializer pop timing
//----------------------------------------------------------
`include "sniffer_cfg.svh"

module tb_bus_sniffer;
  timeunit 1ns;
  timeprecision 1ps;
  import sniffer_pkg::*;

  localparam int HalfPeriod = 50;
  localparam int FrameBits  = `SNIFFER_FRAME_W;
  localparam int FifoDepth  = `SNIFFER_FIFO_DEPTH;
  localparam int DrainLimit = 6000;  // Cycles per drain wait

  logic  clk = 1'b0;
  logic  rst_n;
  logic  instr_req, instr_we, instr_rvalid, instr_gnt;
  addr_t instr_addr;
  data_t instr_wdata, instr_rdata;
  be_t   instr_be;
  logic  data_req, data_we, data_rvalid, data_gnt;
  addr_t data_addr;
  data_t data_wdata, data_rdata;
  be_t   data_be;
  logic  sniffer_tdo;
  logic  sniffer_valid;

  integer seed = 32'hc560;
  string  test_name = "reset";

  // Scoreboard state, updated by the scoreboard block
  frame_t                exp_q[$];
  ts_t                   ts_model;
  int                    occ;        // Modelled FIFO fill
  int                    busy_left;  // Shift clocks left in the serializer
  int                    kept;
  logic [FrameBits-1:0]  rx_bits;
  int                    bit_cnt;
  int                    rx_count;
  logic                  prev_valid;
  int                    mismatches;
  int                    line_faults;

  // Written only by the main flow
  int                    flow_fails;
  int                    timeouts;

  always #HalfPeriod clk = ~clk;

  bus_sniffer uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .instr_req_i     (instr_req),
    .instr_addr_i    (instr_addr),
    .instr_wdata_i   (instr_wdata),
    .instr_be_i      (instr_be),
    .instr_we_i      (instr_we),
    .instr_rvalid_i  (instr_rvalid),
    .instr_rdata_i   (instr_rdata),
    .instr_gnt_i     (instr_gnt),
    .data_req_i      (data_req),
    .data_addr_i     (data_addr),
    .data_wdata_i    (data_wdata),
    .data_be_i       (data_be),
    .data_we_i       (data_we),
    .data_rvalid_i   (data_rvalid),
    .data_rdata_i    (data_rdata),
    .data_gnt_i      (data_gnt),
    .sniffer_tdo_o   (sniffer_tdo),
    .sniffer_valid_o (sniffer_valid)
  );

  //----------------------------------------------------------
  // Frame checking
  //----------------------------------------------------------
  task automatic compare_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      mismatches++;
      $display("ERR %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic check_frame(input frame_t act);
    frame_t exp;
    assert (exp_q.size() > 0) else begin
      line_faults++;
      $display("A frame arrived that was not expected in test %s", test_name);
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      compare_field("source_id", 32'(exp.source_id), 32'(act.source_id));
      compare_field("timestamp", exp.timestamp, act.timestamp);
      compare_field("address", exp.address, act.address);
      compare_field("data", exp.data, act.data);
      compare_field("byte_enable", 32'(exp.byte_enable), 32'(act.byte_enable));
      compare_field("we", 32'(exp.we), 32'(act.we));
      compare_field("valid", 32'(exp.valid), 32'(act.valid));
      compare_field("gnt", 32'(exp.gnt), 32'(act.gnt));
      compare_field("reserved", 32'(exp.reserved), 32'(act.reserved));
    end
  endtask

  //----------------------------------------------------------
  // Scoreboard: reference model, then serial decoder
  //----------------------------------------------------------
  always @(posedge clk) begin : scoreboard
    frame_t f;
    logic   ev;
    logic   pop_m;
    if (!rst_n) begin
      ts_model   = '0;
      occ        = 0;
      busy_left  = 0;
      bit_cnt    = 0;
      prev_valid = 1'b0;
      exp_q.delete();
    end else begin
      ev          = 1'b1;
      f           = '0;
      f.timestamp = ts_model;
      f.valid     = 1'b1;
      if (instr_req) begin
        f.source_id   = `SNIFFER_SRC_INSTR_REQ;
        f.address     = instr_addr;
        f.data        = instr_wdata;
        f.byte_enable = instr_be;
        f.we          = instr_we;
        f.gnt         = 1'b1;
      end else if (instr_rvalid) begin
        f.source_id = `SNIFFER_SRC_INSTR_RESP;
        f.data      = instr_rdata;
        f.gnt       = instr_gnt;
      end else if (data_req) begin
        f.source_id   = `SNIFFER_SRC_DATA_REQ;
        f.address     = data_addr;
        f.data        = data_wdata;
        f.byte_enable = data_be;
        f.we          = data_we;
        f.gnt         = 1'b1;
      end else if (data_rvalid) begin
        f.source_id = `SNIFFER_SRC_DATA_RESP;
        f.data      = data_rdata;
        f.gnt       = data_gnt;
      end else begin
        ev = 1'b0;
      end
      pop_m = (busy_left == 0) && (occ > 0);  // Fill before this edge
      if (ev && occ < FifoDepth) begin  // A full FIFO loses the event
        exp_q.push_back(f);
        kept++;
        occ++;
      end
      if (pop_m) begin
        occ--;
        busy_left = FrameBits;
      end else if (busy_left > 0) begin
        busy_left--;
      end
      ts_model = ts_model + 1;

      // Decoder, LSB arrives first
      if (sniffer_valid) begin
        assert (!(bit_cnt == 0 && prev_valid)) else begin
          line_faults++;
          $display("Valid stayed high past a frame or had no idle clock in test %s",
                   test_name);
        end
        rx_bits = {sniffer_tdo, rx_bits[FrameBits-1:1]};
        bit_cnt++;
        if (bit_cnt == FrameBits) begin
          check_frame(frame_t'(rx_bits));
          bit_cnt = 0;
          rx_count++;
        end
      end else begin
        assert (sniffer_tdo == 1'b0) else begin
          line_faults++;
          $display("The serial line was high with valid low in test %s", test_name);
        end
        assert (bit_cnt == 0) else begin
          line_faults++;
          $display("Valid fell after %0d bits in test %s", bit_cnt, test_name);
        end
        bit_cnt = 0;
      end
      prev_valid = sniffer_valid;
    end
  end

  //----------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------
  task automatic apply_cycle(input logic ireq, input logic irsp, input logic dreq,
                             input logic drsp, input logic we_v, input logic gnt_v);
    @(posedge clk);
    instr_req    <= ireq;
    instr_addr   <= $random(seed);
    instr_wdata  <= $random(seed);
    instr_be     <= be_t'($random(seed));
    instr_we     <= we_v;
    instr_rvalid <= irsp;
    instr_rdata  <= $random(seed);
    instr_gnt    <= gnt_v;
    data_req     <= dreq;
    data_addr    <= $random(seed);
    data_wdata   <= $random(seed);
    data_be      <= be_t'($random(seed));
    data_we      <= we_v;
    data_rvalid  <= drsp;
    data_rdata   <= $random(seed);
    data_gnt     <= gnt_v;
  endtask

  task automatic idle_cycles(input int n);
    for (int k = 0; k < n; k++) begin
      apply_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
  endtask

  // Waits until every kept frame has been received
  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while ((exp_q.size() > 0 || bit_cnt != 0) && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      timeouts++;
      $display("Timed out in test %s with %0d frames still missing", test_name,
               exp_q.size());
    end
    assert (rx_count == kept) else begin
      flow_fails++;
      $display("ERR %s frame_count expected %0d actual %0d", test_name, kept, rx_count);
    end
  endtask

  initial begin
    int i;
    rst_n = 1'b0;
    {instr_req, instr_we, instr_rvalid, instr_gnt} = '0;
    {data_req, data_we, data_rvalid, data_gnt} = '0;
    {instr_addr, instr_wdata, instr_rdata, instr_be} = '0;
    {data_addr, data_wdata, data_rdata, data_be} = '0;
    {kept, rx_count, mismatches, line_faults, flow_fails, timeouts} = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "idle_after_reset";
    for (i = 0; i < 20; i++) begin
      @(posedge clk);
      assert (sniffer_valid == 1'b0 && sniffer_tdo == 1'b0) else begin
        flow_fails++;
        $display("ERR %s valid_tdo expected 00 actual %b%b", test_name, sniffer_valid,
                 sniffer_tdo);
      end
    end

    test_name = "request_frames";
    apply_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);  // Data write
    apply_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);  // Instr fetch
    idle_cycles(2);
    wait_drain(DrainLimit);

    test_name = "response_frames";
    apply_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    apply_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    idle_cycles(2);
    wait_drain(DrainLimit);

    test_name = "ten_in_order";
    for (i = 0; i < 10; i++) begin
      apply_cycle(i % 4 == 0, i % 4 == 1, i % 4 == 2, i % 4 == 3,
                  1'($random(seed)), 1'($random(seed)));
      idle_cycles(1);
    end
    idle_cycles(2);
    wait_drain(DrainLimit);

    test_name = "priority";
    apply_cycle(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);  // Instr beats data
    apply_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);  // Request beats response
    idle_cycles(2);
    wait_drain(DrainLimit);

    test_name = "overflow_burst";
    for (i = 0; i < 30; i++) begin
      apply_cycle(i % 4 == 0, i % 4 == 1, i % 4 == 2, i % 4 == 3,
                  1'($random(seed)), 1'($random(seed)));
    end
    idle_cycles(2);
    wait_drain(DrainLimit);
    idle_cycles(300);  // Nothing more may arrive
    assert (rx_count == kept && bit_cnt == 0) else begin
      flow_fails++;
      $display("Extra frame activity after the burst drained");
    end

    $display("Summary: %0d field mismatches, %0d line faults, %0d flow failures, %0d timeouts",
             mismatches, line_faults, flow_fails, timeouts);
    if (mismatches + line_faults + flow_fails + timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/sniffer_pkg.sv
source/bus_mon_if.sv
source/event_capture.sv
source/frame_fifo.sv
source/frame_serializer.sv
source/bus_sniffer.sv
tb/tb_bus_sniffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bus sniffer testbench with Verilator
# Exit status is nonzero unless the testbench reports a clean run
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       --top-module tb_bus_sniffer -f flist.f \
  && { out=$(./obj_dir/Vtb_bus_sniffer 2>&1); printf '%s\n' "$out"; } \
  && printf '%s\n' "$out" | grep -qx 'No errors' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
